// ==== Makefile ====
# Verilator build and run for the dual-issue testbench

VERILATOR ?= verilator
TOP       ?= tb_issue_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
rtl/issue_pkg.sv
rtl/exec_if.sv
rtl/issue_queue.sv
rtl/issue_scoreboard.sv
rtl/exec_alu.sv
rtl/exec_general.sv
rtl/reg_file.sv
rtl/issue_top.sv
testbench/tb_issue_top.sv

// ==== rtl/exec_alu.sv ====
// unit 1, single-cycle ALU with a registered result one cycle after issue
`timescale 1ns/10ps
`default_nettype none

module exec_alu import issue_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic [31:0] operand_a,
    input  wire logic [31:0] operand_b,
    exec_if.unit             eu
);

    logic        done_q;
    logic [4:0]  rd_q;
    logic [31:0] res_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= eu.en;
        end
    end

    // result payload, held until the next issue
    always_ff @(posedge clk) begin
        if (eu.en) begin
            rd_q  <= dest_reg(eu.entry);
            res_q <= alu_result(eu.entry, operand_a, operand_b);
        end
    end

    assign eu.ready   = 1'b1;
    assign eu.done    = done_q;
    assign eu.done_rd = rd_q;
    assign eu.wdata   = res_q;

    // steering keeps multiplies on unit 0
    a_no_mul: assert property (@(posedge clk) disable iff (!rstn)
        eu.en |-> (eu.entry.op != OP_MUL))
        else $error("mul issued to the alu-only unit");

endmodule

`default_nettype wire

// ==== rtl/exec_general.sv ====
// unit 0, single-cycle ALU ops plus a multicycle multiply that holds off new issue
`timescale 1ns/10ps
`default_nettype none

module exec_general import issue_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic [31:0] operand_a,
    input  wire logic [31:0] operand_b,
    exec_if.unit             eu
);

    localparam int CNT_W = $clog2(MUL_LATENCY + 1);

    logic             is_mul;
    logic             alu_done_q;
    logic             mul_done_q;
    logic             mul_busy;
    logic [CNT_W-1:0] cnt;
    logic [4:0]       rd_q;
    logic [31:0]      alu_res_q;
    logic [31:0]      prod_q;

    assign is_mul = eu.entry.op == OP_MUL;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            alu_done_q <= 1'b0;
            mul_done_q <= 1'b0;
            mul_busy   <= 1'b0;
            cnt        <= '0;
        end else begin
            alu_done_q <= eu.en && !is_mul;
            mul_done_q <= mul_busy && (cnt == CNT_W'(1));
            if (eu.en && is_mul) begin
                mul_busy <= 1'b1;
                cnt      <= CNT_W'(MUL_LATENCY - 1);
            end else if (mul_busy) begin
                cnt <= cnt - CNT_W'(1);
                // unit frees up in the cycle done is seen
                if (cnt == CNT_W'(1)) begin
                    mul_busy <= 1'b0;
                end
            end
        end
    end

    // one rd register is enough, a mul blocks all other issue
    always_ff @(posedge clk) begin
        if (eu.en) begin
            rd_q      <= dest_reg(eu.entry);
            alu_res_q <= alu_result(eu.entry, operand_a, operand_b);
        end
        if (eu.en && is_mul) begin
            prod_q <= operand_a * operand_b;
        end
    end

    assign eu.ready   = !mul_busy;
    assign eu.done    = alu_done_q || mul_done_q;
    assign eu.done_rd = rd_q;
    assign eu.wdata   = mul_done_q ? prod_q : alu_res_q;

    a_single_done: assert property (@(posedge clk) disable iff (!rstn)
        !(alu_done_q && mul_done_q))
        else $error("alu and mul completed together on unit 0");

endmodule

`default_nettype wire

// ==== rtl/exec_if.sv ====
// issue-side link between the scoreboard and one execution unit, one instance per unit
`timescale 1ns/10ps
`default_nettype none

interface exec_if import issue_pkg::*; ();

    logic         en;
    issue_entry_t entry;
    logic         ready;
    // result side, done marks the writeback cycle
    logic         done;
    logic [4:0]   done_rd;
    logic [31:0]  wdata;

    modport issue (
        output en,
        output entry,
        input  ready,
        input  done,
        input  done_rd,
        input  wdata
    );

    modport unit (
        input  en,
        input  entry,
        output ready,
        output done,
        output done_rd,
        output wdata
    );

endinterface

`default_nettype wire

// ==== rtl/issue_pkg.sv ====
// shared micro-op types and helper functions for the dual-issue stage, imported by every block
`default_nettype none

package issue_pkg;

    // unit 0 multiply latency, en to done
    localparam int MUL_LATENCY = 3;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_ADDI = 3'd6,
        OP_MUL  = 3'd7
    } op_t;

    // one micro-op as it sits in the queue
    typedef struct packed {
        op_t         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
    } issue_entry_t;

    // ops that unit 1 can take
    function automatic logic is_alu_op(op_t op);
        return (op != OP_MUL) && (op != OP_NOP);
    endfunction

    // a nop never claims a destination
    function automatic logic [4:0] dest_reg(issue_entry_t e);
        return (e.op == OP_NOP) ? 5'd0 : e.rd;
    endfunction

    // single-cycle datapath shared by both units
    function automatic logic [31:0] alu_result(issue_entry_t e, logic [31:0] a, logic [31:0] b);
        case (e.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + e.imm;
            default: return 32'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rtl/issue_queue.sv ====
// in-order shifting issue queue, takes up to two micro-ops and releases up to two per cycle
`timescale 1ns/10ps
`default_nettype none

module issue_queue import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire logic   clk,
    input  wire logic   rstn,
    input  wire logic   flush,
    input  wire logic   in0_valid,
    input  wire logic   in1_valid,
    input  issue_entry_t in0,
    input  issue_entry_t in1,
    input  wire logic [1:0] pop,
    output logic [1:0]  in_room,
    output issue_entry_t head0,
    output issue_entry_t head1,
    output logic [1:0]  head_count
);

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    issue_entry_t   q      [QUEUE_DEPTH];
    issue_entry_t   q_next [QUEUE_DEPTH];
    logic [CW-1:0]  count;
    logic [CW-1:0]  surv;
    logic [CW-1:0]  free;
    logic           acc0;
    logic           acc1;

    // occupancy once this cycle's pop has gone
    assign surv = count - {{(CW-2){1'b0}}, pop};
    assign free = CW'(QUEUE_DEPTH) - surv;
    assign in_room = (free >= CW'(2)) ? 2'd2 : free[1:0];

    // anything past in_room is dropped
    assign acc0 = in0_valid && (in_room != 2'd0);
    assign acc1 = in1_valid && acc0 && (in_room == 2'd2);

    assign head0 = q[0];
    assign head1 = q[1];
    assign head_count = (count >= CW'(2)) ? 2'd2 : count[1:0];

    always_comb begin
        int src;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            src = i + int'(pop);
            q_next[i] = q[i];
            if (i < int'(surv) && src < QUEUE_DEPTH) begin
                q_next[i] = q[src];
            end else if (i == int'(surv)) begin
                q_next[i] = in0;
            end else if (i == int'(surv) + 1) begin
                // slots past count stay don't-care
                q_next[i] = in1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            q[i] <= q_next[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            count <= surv + CW'(acc0) + CW'(acc1);
        end
    end

    // the scoreboard only pops what it can see
    a_pop_in_range: assert property (@(posedge clk) disable iff (!rstn)
        pop <= head_count)
        else $error("queue popped %0d with %0d at head", pop, head_count);

    // producer honours in_room
    a_offer_in_room: assert property (@(posedge clk) disable iff (!rstn)
        !(in0_valid && in_room == 2'd0) && !(in1_valid && in_room != 2'd2))
        else $error("entry offered beyond in_room %0d", in_room);

    a_in1_needs_in0: assert property (@(posedge clk) disable iff (!rstn)
        in1_valid |-> in0_valid)
        else $error("in1_valid without in0_valid");

endmodule

`default_nettype wire

// ==== rtl/issue_scoreboard.sv ====
// register-busy scoreboard that steers up to two head entries per cycle onto the two units
`timescale 1ns/10ps
`default_nettype none

module issue_scoreboard import issue_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  issue_entry_t     head0,
    input  issue_entry_t     head1,
    input  wire logic [1:0]  head_count,
    output logic [1:0]       pop,
    output logic [3:0][4:0]  rd_addr,
    exec_if.issue            eu0,
    exec_if.issue            eu1
);

    logic [31:0]  busy;
    logic [31:0]  busy_now;
    logic [31:0]  busy_mid;
    logic [31:0]  busy_next;
    logic         h0_to_eu1;
    logic         first_ready;
    logic         second_ready;
    logic         issue_first;
    logic         issue_second;
    issue_entry_t ent0;
    issue_entry_t ent1;

    // sources and destination all free, addi has no rk
    function automatic logic can_issue(issue_entry_t e, logic [31:0] b);
        return !b[e.rj] && (e.op == OP_ADDI || !b[e.rk]) && !b[dest_reg(e)];
    endfunction

    assign h0_to_eu1 = is_alu_op(head0.op);
    assign ent1 = h0_to_eu1 ? head0 : head1;
    assign ent0 = h0_to_eu1 ? head1 : head0;

    assign first_ready  = h0_to_eu1 ? eu1.ready : eu0.ready;
    // unit 1 takes only alu ops as the second entry
    assign second_ready = h0_to_eu1 ? eu0.ready : (eu1.ready && is_alu_op(head1.op));

    always_comb begin
        // results completing this cycle release their registers first
        busy_now = busy;
        if (eu0.done) begin
            busy_now[eu0.done_rd] = 1'b0;
        end
        if (eu1.done) begin
            busy_now[eu1.done_rd] = 1'b0;
        end

        busy_mid = busy_now;
        if (dest_reg(head0) != 5'd0) begin
            busy_mid[dest_reg(head0)] = 1'b1;
        end

        issue_first  = (head_count != 2'd0) && first_ready && can_issue(head0, busy_now);
        issue_second = issue_first && (head_count == 2'd2) && second_ready &&
                       can_issue(head1, busy_mid);

        busy_next = issue_first ? busy_mid : busy_now;
        if (issue_second && dest_reg(head1) != 5'd0) begin
            busy_next[dest_reg(head1)] = 1'b1;
        end
    end

    assign eu1.en    = h0_to_eu1 ? issue_first : issue_second;
    assign eu0.en    = h0_to_eu1 ? issue_second : issue_first;
    assign eu0.entry = ent0;
    assign eu1.entry = ent1;
    assign pop       = {1'b0, issue_first} + {1'b0, issue_second};

    assign rd_addr[0] = ent0.rj;
    assign rd_addr[1] = ent0.rk;
    assign rd_addr[2] = ent1.rj;
    assign rd_addr[3] = ent1.rk;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    a_en_only_ready: assert property (@(posedge clk) disable iff (!rstn)
        !(eu0.en && !eu0.ready) && !(eu1.en && !eu1.ready))
        else $error("issue to a unit that is not ready");

    a_r0_never_busy: assert property (@(posedge clk) disable iff (!rstn)
        !busy[0])
        else $error("r0 marked busy");

    // multiply result lands a fixed time after issue
    a_mul_latency: assert property (@(posedge clk) disable iff (!rstn)
        (eu0.en && eu0.entry.op == OP_MUL) |-> ##MUL_LATENCY eu0.done)
        else $error("mul done missing after %0d cycles", MUL_LATENCY);

endmodule

`default_nettype wire

// ==== rtl/issue_top.sv ====
// dual-issue subsystem top, queue, scoreboard, two units and register file on plain ports
`timescale 1ns/10ps
`default_nettype none

module issue_top import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        flush,
    input  wire logic        in0_valid,
    input  op_t              in0_op,
    input  wire logic [4:0]  in0_rd,
    input  wire logic [4:0]  in0_rj,
    input  wire logic [4:0]  in0_rk,
    input  wire logic [31:0] in0_imm,
    input  wire logic        in1_valid,
    input  op_t              in1_op,
    input  wire logic [4:0]  in1_rd,
    input  wire logic [4:0]  in1_rj,
    input  wire logic [4:0]  in1_rk,
    input  wire logic [31:0] in1_imm,
    input  wire logic [4:0]  dbg_addr,
    output logic [1:0]       in_room,
    output logic             wb0_valid,
    output logic [4:0]       wb0_rd,
    output logic [31:0]      wb0_data,
    output logic             wb1_valid,
    output logic [4:0]       wb1_rd,
    output logic [31:0]      wb1_data,
    output logic [31:0]      dbg_data,
    output logic             idle
);

    issue_entry_t     in0_entry;
    issue_entry_t     in1_entry;
    issue_entry_t     head0;
    issue_entry_t     head1;
    logic [1:0]       head_count;
    logic [1:0]       pop;
    logic [3:0][4:0]  rd_addr;
    logic [3:0][31:0] rd_data;

    exec_if eu0_bus ();
    exec_if eu1_bus ();

    assign in0_entry = '{op: in0_op, rd: in0_rd, rj: in0_rj, rk: in0_rk, imm: in0_imm};
    assign in1_entry = '{op: in1_op, rd: in1_rd, rj: in1_rj, rk: in1_rk, imm: in1_imm};

    issue_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .in0_valid  (in0_valid),
        .in1_valid  (in1_valid),
        .in0        (in0_entry),
        .in1        (in1_entry),
        .pop        (pop),
        .in_room    (in_room),
        .head0      (head0),
        .head1      (head1),
        .head_count (head_count)
    );

    issue_scoreboard u_scoreboard (
        .clk        (clk),
        .rstn       (rstn),
        .head0      (head0),
        .head1      (head1),
        .head_count (head_count),
        .pop        (pop),
        .rd_addr    (rd_addr),
        .eu0        (eu0_bus.issue),
        .eu1        (eu1_bus.issue)
    );

    // unit 0 takes anything, unit 1 only alu ops
    exec_general u_eu0 (
        .clk       (clk),
        .rstn      (rstn),
        .operand_a (rd_data[0]),
        .operand_b (rd_data[1]),
        .eu        (eu0_bus.unit)
    );

    exec_alu u_eu1 (
        .clk       (clk),
        .rstn      (rstn),
        .operand_a (rd_data[2]),
        .operand_b (rd_data[3]),
        .eu        (eu1_bus.unit)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .rd_addr  (rd_addr),
        .we0      (eu0_bus.done),
        .waddr0   (eu0_bus.done_rd),
        .wdata0   (eu0_bus.wdata),
        .we1      (eu1_bus.done),
        .waddr1   (eu1_bus.done_rd),
        .wdata1   (eu1_bus.wdata),
        .dbg_addr (dbg_addr),
        .rd_data  (rd_data),
        .dbg_data (dbg_data)
    );

    assign wb0_valid = eu0_bus.done;
    assign wb0_rd    = eu0_bus.done_rd;
    assign wb0_data  = eu0_bus.wdata;
    assign wb1_valid = eu1_bus.done;
    assign wb1_rd    = eu1_bus.done_rd;
    assign wb1_data  = eu1_bus.wdata;

    // nothing queued, nothing in flight, no write pending
    assign idle = (head_count == 2'd0) && eu0_bus.ready && eu1_bus.ready &&
                  !eu0_bus.done && !eu1_bus.done;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// 32x32 integer register file, four operand reads, two writes and a debug read
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic [3:0][4:0]   rd_addr,
    input  wire logic              we0,
    input  wire logic [4:0]        waddr0,
    input  wire logic [31:0]       wdata0,
    input  wire logic              we1,
    input  wire logic [4:0]        waddr1,
    input  wire logic [31:0]       wdata1,
    input  wire logic [4:0]        dbg_addr,
    output logic      [3:0][31:0]  rd_data,
    output logic      [31:0]       dbg_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            if (we0 && waddr0 != 5'd0) begin
                regs[waddr0] <= wdata0;
            end
            if (we1 && waddr1 != 5'd0) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // r0 reads as zero whatever was written
    // a result written at this edge is already seen by a reader issuing now
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (rd_addr[p] == 5'd0) begin
                rd_data[p] = 32'd0;
            end else if (we0 && waddr0 == rd_addr[p]) begin
                rd_data[p] = wdata0;
            end else if (we1 && waddr1 == rd_addr[p]) begin
                rd_data[p] = wdata1;
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

    assign dbg_data = (dbg_addr == 5'd0) ? 32'd0 : regs[dbg_addr];

    // busy tracking upstream keeps the two units off the same register
    a_no_write_clash: assert property (@(posedge clk) disable iff (!rstn)
        !(we0 && we1 && waddr0 == waddr1 && waddr0 != 5'd0))
        else $error("both write ports hit r%0d", waddr0);

endmodule

`default_nettype wire

// ==== testbench/tb_issue_top.sv ====
// testbench for issue_top, feeds micro-op groups from a table and checks registers against a model
`timescale 1ns/10ps
`default_nettype none

module tb_issue_top import issue_pkg::*; ();

    localparam int QUEUE_DEPTH = 8;
    localparam int BP_GROUP    = 3;

    typedef struct {
        op_t         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        bit          last;
        bit          flushed;
    } row_t;

    // one register write, seen on a port or predicted by the model
    typedef struct {
        bit          unit0;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        in0_valid;
    op_t         in0_op;
    logic [4:0]  in0_rd;
    logic [4:0]  in0_rj;
    logic [4:0]  in0_rk;
    logic [31:0] in0_imm;
    logic        in1_valid;
    op_t         in1_op;
    logic [4:0]  in1_rd;
    logic [4:0]  in1_rj;
    logic [4:0]  in1_rk;
    logic [31:0] in1_imm;
    logic [4:0]  dbg_addr;
    logic [1:0]  in_room;
    logic        wb0_valid;
    logic [4:0]  wb0_rd;
    logic [31:0] wb0_data;
    logic        wb1_valid;
    logic [4:0]  wb1_rd;
    logic [31:0] wb1_data;
    logic [31:0] dbg_data;
    logic        idle;

    row_t        rows[$];
    logic [31:0] shadow[32];
    wb_t         wb_log[$];
    wb_t         wb_exp[$];
    int          errors;
    int          checks;
    bit          table_ready;

    issue_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_dut (
        .clk(clk), .rstn(rstn), .flush(flush),
        .in0_valid(in0_valid), .in0_op(in0_op), .in0_rd(in0_rd),
        .in0_rj(in0_rj), .in0_rk(in0_rk), .in0_imm(in0_imm),
        .in1_valid(in1_valid), .in1_op(in1_op), .in1_rd(in1_rd),
        .in1_rj(in1_rj), .in1_rk(in1_rk), .in1_imm(in1_imm),
        .dbg_addr(dbg_addr), .in_room(in_room),
        .wb0_valid(wb0_valid), .wb0_rd(wb0_rd), .wb0_data(wb0_data),
        .wb1_valid(wb1_valid), .wb1_rd(wb1_rd), .wb1_data(wb1_data),
        .dbg_data(dbg_data), .idle(idle)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // writebacks logged mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (wb0_valid) begin
                wb_log.push_back('{1'b1, wb0_rd, wb0_data});
            end
            if (wb1_valid) begin
                wb_log.push_back('{1'b0, wb1_rd, wb1_data});
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic add_row(input op_t op, input int rd, input int rj, input int rk,
                           input logic [31:0] imm, input bit last, input bit flushed = 1'b0);
        rows.push_back('{op, 5'(rd), 5'(rj), 5'(rk), imm, last, flushed});
    endtask

    task automatic build_table();
        op_t rop;
        // group 0, seeds and writes aimed at r0
        add_row(OP_ADDI, 1, 0, 0, 32'h0000_0011, 1'b0);
        add_row(OP_ADDI, 2, 0, 0, 32'h0000_2222, 1'b0);
        add_row(OP_ADDI, 3, 0, 0, 32'h0003_0303, 1'b0);
        add_row(OP_ADDI, 4, 0, 0, 32'hffff_fff0, 1'b0);
        add_row(OP_ADDI, 0, 0, 0, 32'h0000_0055, 1'b0);
        add_row(OP_ADD,  0, 1, 2, 32'h0, 1'b0);
        add_row(OP_ADDI, 5, 0, 0, 32'h0000_0007, 1'b0);
        add_row(OP_XOR,  0, 3, 4, 32'h0, 1'b1);
        // group 1, raw and waw chains, some inside one pair
        add_row(OP_ADD,  6, 1, 2, 32'h0, 1'b0);
        add_row(OP_SUB,  7, 6, 3, 32'h0, 1'b0);
        add_row(OP_XOR,  6, 7, 4, 32'h0, 1'b0);
        add_row(OP_OR,   8, 6, 1, 32'h0, 1'b0);
        add_row(OP_AND,  9, 8, 7, 32'h0, 1'b0);
        add_row(OP_ADDI, 9, 9, 0, 32'h0000_0001, 1'b0);
        add_row(OP_ADD, 10, 9, 9, 32'h0, 1'b0);
        add_row(OP_SUB, 10, 10, 6, 32'h0, 1'b1);
        // group 2, multiplies with dependents
        add_row(OP_MUL, 11, 1, 2, 32'h0, 1'b0);
        add_row(OP_ADD, 12, 11, 3, 32'h0, 1'b0);
        add_row(OP_MUL, 13, 12, 4, 32'h0, 1'b0);
        add_row(OP_XOR, 14, 13, 11, 32'h0, 1'b0);
        add_row(OP_ADDI, 15, 0, 0, 32'h0000_0005, 1'b0);
        add_row(OP_MUL, 16, 15, 15, 32'h0, 1'b0);
        add_row(OP_SUB, 17, 16, 14, 32'h0, 1'b0);
        add_row(OP_MUL, 11, 11, 3, 32'h0, 1'b1);
        // group 3, back-to-back multiplies to fill the queue
        for (int i = 0; i < 14; i++) begin
            add_row(OP_MUL, 18 + i % 8, 1 + i % 5, 2 + i % 3, 32'h0, i == 13);
        end
        // group 4, dependents of r1 get flushed while the mul runs
        add_row(OP_MUL, 1, 2, 3, 32'h0, 1'b0);
        add_row(OP_ADD, 4, 1, 2, 32'h0, 1'b0, 1'b1);
        add_row(OP_XOR, 5, 1, 3, 32'h0, 1'b1, 1'b1);
        // group 5, random mix
        for (int i = 0; i < 40; i++) begin
            rop = op_t'(3'($urandom % 7 + 1));
            add_row(rop, $urandom % 32, $urandom % 32, $urandom % 32, $urandom, i == 39);
        end
    endtask

    // sequential reference, one micro-op at a time
    function automatic logic [31:0] model_step(row_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = shadow[r.rj];
        b = shadow[r.rk];
        case (r.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + r.imm;
            OP_MUL:  res = a * b;
            default: res = 32'd0;
        endcase
        if (r.op != OP_NOP && r.rd != 5'd0) begin
            shadow[r.rd] = res;
        end
        return res;
    endfunction

    task automatic drive_port(input int port, input row_t r);
        if (port == 0) begin
            in0_valid = 1'b1;
            in0_op    = r.op;
            in0_rd    = r.rd;
            in0_rj    = r.rj;
            in0_rk    = r.rk;
            in0_imm   = r.imm;
        end else begin
            in1_valid = 1'b1;
            in1_op    = r.op;
            in1_rd    = r.rd;
            in1_rj    = r.rj;
            in1_rk    = r.rk;
            in1_imm   = r.imm;
        end
    endtask

    task automatic compare_registers();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #10;
            dbg_addr = 5'(i);
            #40;
            check_value($sformatf("dbg_data r%0d", i), dbg_data, shadow[i]);
        end
    endtask

    // writes to one register keep program order, so match the oldest one pending
    task automatic match_writebacks();
        int k;
        for (int n = 0; n < wb_log.size(); n++) begin
            if (wb_log[n].rd != 5'd0) begin
                k = -1;
                for (int e = 0; e < wb_exp.size(); e++) begin
                    if (k < 0 && wb_exp[e].rd == wb_log[n].rd) begin
                        k = e;
                    end
                end
                if (k < 0) begin
                    errors++;
                    $display("writeback to r%0d was not expected by the model",
                             wb_log[n].rd);
                end else begin
                    check_value($sformatf("wb%0d_data r%0d", wb_log[n].unit0 ? 0 : 1,
                                          wb_log[n].rd),
                                wb_log[n].data, wb_exp[k].data);
                    if (wb_exp[k].unit0) begin
                        check_value("wb0_valid on mul", 32'(wb_log[n].unit0), 32'd1);
                    end
                    wb_exp.delete(k);
                end
            end
        end
        check_value("writebacks missing", 32'(wb_exp.size()), 32'd0);
    endtask

    initial begin
        int idx;
        int start;
        int grp;
        int executed;
        bit fed_last;
        bit need_flush;
        bit saw_full;
        logic [31:0] res;
        void'($urandom(26));
        errors = 0;
        checks = 0;
        table_ready = 1'b0;
        rstn = 1'b0;
        flush = 1'b0;
        in0_valid = 1'b0;
        in0_op = OP_NOP;
        in0_rd = '0;
        in0_rj = '0;
        in0_rk = '0;
        in0_imm = '0;
        in1_valid = 1'b0;
        in1_op = OP_NOP;
        in1_rd = '0;
        in1_rj = '0;
        in1_rk = '0;
        in1_imm = '0;
        dbg_addr = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        rstn = 1'b1;

        idx = 0;
        grp = 0;
        while (idx < rows.size()) begin
            start = idx;
            fed_last = 1'b0;
            need_flush = 1'b0;
            saw_full = 1'b0;
            wb_log.delete();
            wb_exp.delete();
            // offer up to in_room rows per cycle, never past the group end
            while (!fed_last) begin
                @(posedge clk);
                #10;
                in0_valid = 1'b0;
                in1_valid = 1'b0;
                if (in_room == 2'd0) saw_full = 1'b1;
                for (int p = 0; p < 2; p++) begin
                    if (!fed_last && int'(in_room) > p) begin
                        drive_port(p, rows[idx]);
                        need_flush |= rows[idx].flushed;
                        fed_last = rows[idx].last;
                        idx++;
                    end
                end
            end
            @(posedge clk);
            #10;
            in0_valid = 1'b0;
            in1_valid = 1'b0;
            // flushed rows are now at the head, mul still running
            if (need_flush) begin
                flush = 1'b1;
                @(posedge clk);
                #10;
                flush = 1'b0;
            end
            while (!idle) begin
                @(posedge clk);
                #10;
            end

            executed = 0;
            for (int i = start; i < idx; i++) begin
                if (!rows[i].flushed) begin
                    res = model_step(rows[i]);
                    executed++;
                    if (rows[i].op != OP_NOP && rows[i].rd != 5'd0) begin
                        wb_exp.push_back('{rows[i].op == OP_MUL, rows[i].rd, res});
                    end
                end
            end
            compare_registers();
            check_value("wb0_valid+wb1_valid count", wb_log.size(), executed);
            match_writebacks();
            if (grp == BP_GROUP) begin
                check_value("in_room reached 0", 32'(saw_full), 32'd1);
            end
            grp++;
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * 20 + 200) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", rows.size() * 20 + 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
